/* build.f */
+incdir+include
design/video_pkg.sv
design/cpu_bus_pkg.sv
design/layer_prio.sv
design/pal_ram.sv
design/pal_cpu_port.sv
design/blank_delay.sv
design/colmix_top.sv
tb/tb_colmix.sv

/* tb/tb_colmix.sv */
/*
 * colour mixer testbench
 * directed tests of the CPU palette port, layer priority and
 * colour/blank alignment against a palette and priority model
 */
`timescale 1ns/1ps
`include "colmix_cfg.svh"

module tb_colmix;

    import video_pkg::*;
    import cpu_bus_pkg::*;

    localparam int DLY        = `COLMIX_BLANK_DLY;
    localparam int DEPTH      = 2 ** `COLMIX_PAL_AW;
    localparam int WAIT_LIMIT = 20;

    logic        clk;
    logic        rst_n;
    logic        pxl_cen;
    logic        hblank_n;
    logic        vblank_n;
    logic [6:0]  char_pxl;
    logic [10:0] scr1_pxl;
    logic [10:0] scr2_pxl;
    logic [11:0] obj_pxl;
    logic        cpu_valid;
    logic        cpu_ready;
    cpu_op_e     cpu_op;
    pal_addr_t   cpu_addr;
    logic [15:0] cpu_wdata;
    byte_en_t    cpu_be;
    logic        rsp_valid;
    logic [15:0] rsp_rdata;
    logic [4:0]  red;
    logic [4:0]  green;
    logic [4:0]  blue;
    logic        hblank_n_dly;
    logic        vblank_n_dly;

    // palette mirror
    logic [15:0] pal_model [DEPTH];
    // expected output per pixel, {vblank_n, hblank_n, colour}
    logic [16:0] pix_q [$];
    int          cen_cnt = 0;

    colmix_top u_dut (.*);

    always #50 clk = ~clk;

    // pixel enable on every third clock
    always @(posedge clk) begin
        #1;
        cen_cnt = (cen_cnt == 2) ? 0 : cen_cnt + 1;
        pxl_cen = (cen_cnt == 2);
    end

    task automatic stop_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0t ns: %s", $time, what);
        stop_run();
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h",
                     $time, name, got, exp);
            stop_run();
        end
    endtask

    // object entries need pen bits 3:0, tiles only 2:0
    function automatic logic layer_opaque(input pal_addr_t a);
        if (a[10]) begin
            return a[3:0] != 4'd0;
        end
        return a[2:0] != 3'd0;
    endfunction

    function automatic pal_addr_t model_addr(input logic [6:0] ch, input logic [10:0] s1,
                                             input logic [10:0] s2, input logic [11:0] ob);
        pal_addr_t l0;
        pal_addr_t l1;
        pal_addr_t l2;
        logic      pen;
        pen = (ob[3:0] != 4'd0);
        l0 = {5'd0, ch[5:0]};
        l1 = {1'b0, s1[9:0]};
        l2 = {1'b0, s2[9:0]};
        // object takes a layer when its priority field names that layer
        if (pen && !ch[6] && ob[11:10] == PRIO_CHAR) begin
            l0 = {1'b1, ob[9:0]};
        end
        if (pen && !s1[10] && ob[11:10] == PRIO_SCR1) begin
            l1 = {1'b1, ob[9:0]};
        end
        if (pen && !s2[10] && ob[11:10] == PRIO_SCR2) begin
            l2 = {1'b1, ob[9:0]};
        end
        if (layer_opaque(l0)) begin
            return l0;
        end else if (layer_opaque(l1)) begin
            return l1;
        end else if (layer_opaque(l2)) begin
            return l2;
        end
        // backdrop
        return '0;
    endfunction

    // random tile pixel, priority in bit 10
    function automatic logic [10:0] rand_tile(input logic opaque);
        logic [10:0] t;
        t = 11'($urandom);
        if (!opaque) begin
            t[2:0] = 3'd0;
        end else if (t[2:0] == 3'd0) begin
            t[0] = 1'b1;
        end
        return t;
    endfunction

    // returns 1 ns after the next edge with pxl_cen high
    task automatic wait_pixel_enable();
        int   n;
        logic hit;
        n   = 0;
        hit = 1'b0;
        while (!hit) begin
            @(posedge clk);
            hit = pxl_cen;
            #1;
            n++;
            if (!hit && n >= WAIT_LIMIT) begin
                report_timeout("pxl_cen never went high");
            end
        end
    endtask

    // checks the pixel from DLY+1 steps back, then presents a new one
    task automatic pixel_step(input logic [6:0] ch, input logic [10:0] s1,
                              input logic [10:0] s2, input logic [11:0] ob,
                              input logic hb, input logic vb);
        logic [16:0] e;
        wait_pixel_enable();
        if (pix_q.size() > DLY) begin
            e = pix_q.pop_front();
            // low bit of each channel sits at position 0
            check_value("red", red, {e[3:0], e[12]});
            check_value("green", green, {e[7:4], e[13]});
            check_value("blue", blue, {e[11:8], e[14]});
            check_value("hblank_n_dly", hblank_n_dly, e[15]);
            check_value("vblank_n_dly", vblank_n_dly, e[16]);
        end
        char_pxl = ch;
        scr1_pxl = s1;
        scr2_pxl = s2;
        obj_pxl  = ob;
        hblank_n = hb;
        vblank_n = vb;
        pix_q.push_back({vb, hb, pal_model[model_addr(ch, s1, s2, ob)][14:0]});
    endtask

    task automatic drain_pipe();
        for (int i = 0; i <= DLY; i++) begin
            pixel_step(7'd0, 11'd0, 11'd0, 12'd0, 1'b1, 1'b1);
        end
    endtask

    // request handshake, returns 1 ns after the accepting edge
    task automatic cpu_request(input cpu_op_e op, input pal_addr_t a,
                               input logic [15:0] d, input byte_en_t be);
        int   n;
        logic acc;
        cpu_valid = 1'b1;
        cpu_op    = op;
        cpu_addr  = a;
        cpu_wdata = d;
        cpu_be    = be;
        n   = 0;
        acc = 1'b0;
        while (!acc) begin
            acc = cpu_ready;
            @(posedge clk);
            #1;
            n++;
            if (!acc && n >= WAIT_LIMIT) begin
                report_timeout("CPU request never accepted");
            end
        end
        cpu_valid = 1'b0;
    endtask

    task automatic cpu_write(input pal_addr_t a, input logic [15:0] d, input byte_en_t be);
        cpu_request(CPU_WRITE, a, d, be);
        if (be[0]) begin
            pal_model[a][7:0] = d[7:0];
        end
        if (be[1]) begin
            pal_model[a][15:8] = d[15:8];
        end
        // writes never stall the port
        check_value("cpu_ready", cpu_ready, 1);
    endtask

    task automatic cpu_read(input pal_addr_t a);
        int   n;
        logic seen;
        cpu_request(CPU_READ, a, 16'd0, 2'b00);
        check_value("cpu_ready", cpu_ready, 0);
        check_value("rsp_valid", rsp_valid, 0);
        n    = 0;
        seen = 1'b0;
        while (!seen) begin
            @(posedge clk);
            #1;
            n++;
            seen = rsp_valid;
            if (!seen && n >= WAIT_LIMIT) begin
                report_timeout("read response never arrived");
            end
        end
        check_value("rsp latency", n, 1);
        check_value("rsp_rdata", rsp_rdata, pal_model[a]);
        check_value("cpu_ready", cpu_ready, 1);
        @(posedge clk);
        #1;
        // strobe lasts one cycle
        check_value("rsp_valid", rsp_valid, 0);
    endtask

    task automatic reset_state();
        check_value("cpu_ready", cpu_ready, 1);
        check_value("rsp_valid", rsp_valid, 0);
        // delay line is black and blanked
        check_value("red", red, 0);
        check_value("green", green, 0);
        check_value("blue", blue, 0);
        check_value("hblank_n_dly", hblank_n_dly, 0);
        check_value("vblank_n_dly", vblank_n_dly, 0);
    endtask

    task automatic cpu_access();
        pal_addr_t a;
        // full palette first, later tests need known words
        for (int i = 0; i < DEPTH; i++) begin
            cpu_write(pal_addr_t'(i), 16'($urandom), 2'b11);
        end
        // byte writes then read back the same word
        for (int i = 0; i < 48; i++) begin
            a = pal_addr_t'($urandom);
            cpu_write(a, 16'($urandom), byte_en_t'($urandom));
            cpu_read(a);
        end
        for (int i = 0; i < 32; i++) begin
            cpu_read(pal_addr_t'($urandom));
        end
    endtask

    task automatic layer_order();
        logic [2:0]  opq;
        logic [10:0] c;
        pix_q.delete();
        // every opacity mix of char, scroll 1, scroll 2, object pen zero
        for (int i = 0; i < 48; i++) begin
            opq = 3'(i);
            c   = rand_tile(opq[0]);
            pixel_step({c[10], c[5:0]}, rand_tile(opq[1]), rand_tile(opq[2]),
                       {2'(i), 10'($urandom) & 10'h3f0}, 1'b1, 1'b1);
        end
        drain_pipe();
    endtask

    task automatic object_priority();
        logic [10:0] c;
        logic [10:0] s1;
        logic [10:0] s2;
        logic [9:0]  oc;
        pix_q.delete();
        for (int p = 0; p < 4; p++) begin
            for (int tp = 0; tp < 8; tp++) begin
                for (int pen = 0; pen < 4; pen++) begin
                    oc = 10'($urandom);
                    if (pen[0]) begin
                        oc[3:0] = 4'd0;
                    end else if (oc[3:0] == 4'd0) begin
                        oc[3] = 1'b1;
                    end
                    c = rand_tile($urandom % 2);
                    c[10] = tp[0];
                    // tile priority bits from the sweep
                    s1 = rand_tile($urandom % 2);
                    s1[10] = tp[1];
                    s2 = rand_tile($urandom % 2);
                    s2[10] = tp[2];
                    pixel_step({c[10], c[5:0]}, s1, s2,
                               {2'(p), oc}, 1'b1, 1'b1);
                end
            end
        end
        drain_pipe();
    endtask

    task automatic blank_alignment();
        logic [1:0] flg;
        pix_q.delete();
        for (int i = 0; i < 40; i++) begin
            flg = 2'(i) ^ 2'($urandom);
            pixel_step(7'($urandom), 11'($urandom), 11'($urandom), 12'($urandom),
                       flg[0], flg[1]);
        end
        drain_pipe();
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        pxl_cen   = 1'b0;
        hblank_n  = 1'b0;
        vblank_n  = 1'b0;
        char_pxl  = '0;
        scr1_pxl  = '0;
        scr2_pxl  = '0;
        obj_pxl   = '0;
        cpu_valid = 1'b0;
        cpu_op    = CPU_READ;
        cpu_addr  = '0;
        cpu_wdata = '0;
        cpu_be    = '0;
        void'($urandom(32'h5ea8_7dc5));
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        reset_state();
        cpu_access();
        layer_order();
        object_priority();
        blank_alignment();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* design/colmix_top.sv */
/*
 * colour mixer top
 * layer priority, palette lookup, CPU palette port and blank delay
 */
`timescale 1ns/1ps
`include "colmix_cfg.svh"

module colmix_top (
    input  logic                                 clk,
    input  logic                                 rst_n,
    // video in
    input  logic                                 pxl_cen,
    input  logic                                 hblank_n,
    input  logic                                 vblank_n,
    input  logic [video_pkg::CHAR_PXL_W-1:0]     char_pxl,
    input  logic [video_pkg::SCR_PXL_W-1:0]      scr1_pxl,
    input  logic [video_pkg::SCR_PXL_W-1:0]      scr2_pxl,
    input  logic [video_pkg::OBJ_PXL_W-1:0]      obj_pxl,
    // CPU request
    input  logic                                 cpu_valid,
    output logic                                 cpu_ready,
    input  cpu_bus_pkg::cpu_op_e                 cpu_op,
    input  video_pkg::pal_addr_t                 cpu_addr,
    input  logic [`COLMIX_PAL_DW-1:0]            cpu_wdata,
    input  cpu_bus_pkg::byte_en_t                cpu_be,
    // CPU response
    output logic                                 rsp_valid,
    output logic [`COLMIX_PAL_DW-1:0]            rsp_rdata,
    // video out
    output logic [4:0]                           red,
    output logic [4:0]                           green,
    output logic [4:0]                           blue,
    output logic                                 hblank_n_dly,
    output logic                                 vblank_n_dly
);

    import video_pkg::*;
    import cpu_bus_pkg::*;

    pal_addr_t                 pal_addr;
    rgb15_t                    pal_rgb;
    rgb15_t                    rgb_dly;
    pal_addr_t                 ram_addr;
    logic [`COLMIX_PAL_DW-1:0] ram_wdata;
    byte_en_t                  ram_we;
    logic [`COLMIX_PAL_DW-1:0] ram_q;

    layer_prio u_prio (
        .clk      (clk),
        .rst_n    (rst_n),
        .pxl_cen  (pxl_cen),
        .char_pxl (char_pxl),
        .scr1_pxl (scr1_pxl),
        .scr2_pxl (scr2_pxl),
        .obj_pxl  (obj_pxl),
        .pal_addr (pal_addr)
    );

    pal_cpu_port u_cpu (
        .clk       (clk),
        .rst_n     (rst_n),
        .cpu_valid (cpu_valid),
        .cpu_ready (cpu_ready),
        .cpu_op    (cpu_op),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_be    (cpu_be),
        .rsp_valid (rsp_valid),
        .rsp_rdata (rsp_rdata),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_we    (ram_we),
        .ram_q     (ram_q)
    );

    pal_ram u_pal (
        .clk       (clk),
        .cpu_addr  (ram_addr),
        .cpu_wdata (ram_wdata),
        .cpu_we    (ram_we),
        .cpu_q     (ram_q),
        .vid_addr  (pal_addr),
        .vid_q     (pal_rgb)
    );

    blank_delay u_blank (
        .clk          (clk),
        .rst_n        (rst_n),
        .pxl_cen      (pxl_cen),
        .hblank_n     (hblank_n),
        .vblank_n     (vblank_n),
        .rgb_in       (pal_rgb),
        .rgb_out      (rgb_dly),
        .hblank_n_dly (hblank_n_dly),
        .vblank_n_dly (vblank_n_dly)
    );

    // 4 high bits on top, extra low bit at position 0
    assign red   = {rgb_dly.r_hi, rgb_dly.r_lo};
    assign green = {rgb_dly.g_hi, rgb_dly.g_lo};
    assign blue  = {rgb_dly.b_hi, rgb_dly.b_lo};

endmodule

/* design/blank_delay.sv */
/*
 * colour and blanking delay line
 * shifts at pixel enables, flags get one extra stage since they
 * enter before the palette colour does
 */
`timescale 1ns/1ps
`include "colmix_cfg.svh"

module blank_delay (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                pxl_cen,
    input  logic                hblank_n,
    input  logic                vblank_n,
    input  video_pkg::rgb15_t   rgb_in,
    output video_pkg::rgb15_t   rgb_out,
    output logic                hblank_n_dly,
    output logic                vblank_n_dly
);

    import video_pkg::*;

    localparam int DLY = `COLMIX_BLANK_DLY;

    // colour enters at enable k+1, flags at enable k
    rgb15_t     col_sr [DLY];
    // bit 1 vblank, bit 0 hblank
    logic [1:0] blk_sr [DLY+1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // black, blanked
            for (int i = 0; i < DLY; i++) begin
                col_sr[i] <= '0;
            end
            for (int i = 0; i <= DLY; i++) begin
                blk_sr[i] <= 2'b00;
            end
        end else if (pxl_cen) begin
            col_sr[0] <= rgb_in;
            blk_sr[0] <= {vblank_n, hblank_n};
            for (int i = 1; i < DLY; i++) begin
                col_sr[i] <= col_sr[i-1];
            end
            for (int i = 1; i <= DLY; i++) begin
                blk_sr[i] <= blk_sr[i-1];
            end
        end
    end

    assign rgb_out      = col_sr[DLY-1];
    assign hblank_n_dly = blk_sr[DLY][0];
    assign vblank_n_dly = blk_sr[DLY][1];

endmodule

/* design/pal_cpu_port.sv */
/*
 * CPU palette port
 * valid/ready request handshake, byte-enabled writes and
 * one-cycle read response strobe
 */
`timescale 1ns/1ps
`include "colmix_cfg.svh"

module pal_cpu_port (
    input  logic                        clk,
    input  logic                        rst_n,
    // request
    input  logic                        cpu_valid,
    output logic                        cpu_ready,
    input  cpu_bus_pkg::cpu_op_e        cpu_op,
    input  video_pkg::pal_addr_t        cpu_addr,
    input  logic [`COLMIX_PAL_DW-1:0]   cpu_wdata,
    input  cpu_bus_pkg::byte_en_t       cpu_be,
    // response
    output logic                        rsp_valid,
    output logic [`COLMIX_PAL_DW-1:0]   rsp_rdata,
    // RAM side
    output video_pkg::pal_addr_t        ram_addr,
    output logic [`COLMIX_PAL_DW-1:0]   ram_wdata,
    output cpu_bus_pkg::byte_en_t       ram_we,
    input  logic [`COLMIX_PAL_DW-1:0]   ram_q
);

    import cpu_bus_pkg::*;

    typedef enum logic {
        PORT_IDLE,
        PORT_READ
    } port_state_e;

    port_state_e state;
    logic        wr_acc;
    logic        rd_acc;

    // only idle takes requests
    assign cpu_ready = (state == PORT_IDLE);
    assign wr_acc    = cpu_valid && cpu_ready && (cpu_op == CPU_WRITE);
    assign rd_acc    = cpu_valid && cpu_ready && (cpu_op == CPU_READ);

    // RAM sees the request on the accepting edge
    assign ram_addr  = cpu_addr;
    assign ram_wdata = cpu_wdata;
    assign ram_we    = wr_acc ? cpu_be : '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= PORT_IDLE;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= 1'b0;
            case (state)
                PORT_IDLE: begin
                    if (rd_acc) begin
                        state <= PORT_READ;
                    end
                end
                // RAM word is ready, strobe it out
                PORT_READ: begin
                    state     <= PORT_IDLE;
                    rsp_valid <= 1'b1;
                end
                default: begin
                    state <= PORT_IDLE;
                end
            endcase
        end
    end

    // read data held while rsp_valid is high
    always_ff @(posedge clk) begin
        if (state == PORT_READ) begin
            rsp_rdata <= ram_q;
        end
    end

    // response strobe is a single cycle
    rsp_pulse_a: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid |=> !rsp_valid);

    // accepted read stalls the request side, then answers
    rd_wait_a: assert property (@(posedge clk) disable iff (!rst_n)
        rd_acc |=> !cpu_ready ##1 rsp_valid);

endmodule

/* design/pal_ram.sv */
/*
 * palette RAM
 * dual port, read first, byte writes from the CPU side,
 * video side reads only
 */
`timescale 1ns/1ps
`include "colmix_cfg.svh"

module pal_ram (
    input  logic                        clk,
    // CPU side
    input  video_pkg::pal_addr_t        cpu_addr,
    input  logic [`COLMIX_PAL_DW-1:0]   cpu_wdata,
    input  cpu_bus_pkg::byte_en_t       cpu_we,
    output logic [`COLMIX_PAL_DW-1:0]   cpu_q,
    // video side
    input  video_pkg::pal_addr_t        vid_addr,
    output video_pkg::rgb15_t           vid_q
);

    import cpu_bus_pkg::*;

    localparam int DEPTH = 2 ** `COLMIX_PAL_AW;

    logic [`COLMIX_PAL_DW-1:0] mem [DEPTH];

    // CPU port
    // old word comes back on the same edge as a write
    always_ff @(posedge clk) begin
        if (cpu_we[BE_LO]) begin
            mem[cpu_addr][7:0] <= cpu_wdata[7:0];
        end
        if (cpu_we[BE_HI]) begin
            mem[cpu_addr][15:8] <= cpu_wdata[15:8];
        end
        cpu_q <= mem[cpu_addr];
    end

    // video port
    // top bit of the word is not a colour bit
    always_ff @(posedge clk) begin
        vid_q <= mem[vid_addr][14:0];
    end

endmodule

/* design/layer_prio.sv */
/*
 * layer priority
 * merges the object into each tile layer and picks the first opaque
 * layer, giving the palette address for the video read
 */
`timescale 1ns/1ps

module layer_prio (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 pxl_cen,
    input  logic [video_pkg::CHAR_PXL_W-1:0]     char_pxl,
    input  logic [video_pkg::SCR_PXL_W-1:0]      scr1_pxl,
    input  logic [video_pkg::SCR_PXL_W-1:0]      scr2_pxl,
    input  logic [video_pkg::OBJ_PXL_W-1:0]      obj_pxl,
    output video_pkg::pal_addr_t                 pal_addr
);

    import video_pkg::*;

    // merged layers, 0 char, 1 scroll 1, 2 scroll 2
    pal_addr_t lyr0;
    pal_addr_t lyr1;
    pal_addr_t lyr2;

    obj_prio_e obj_prio;
    logic      obj_pen_nz;

    assign obj_prio   = obj_prio_e'(obj_pxl[11:10]);
    // pen 0 is transparent for objects
    assign obj_pen_nz = |obj_pxl[3:0];

    // object takes the layer only with a visible pen,
    // a low tile priority bit and a matching priority field
    function automatic pal_addr_t merge_layer(
        input logic [9:0] tile_col,
        input logic       tile_prio,
        input logic [9:0] obj_col,
        input logic       obj_pen,
        input logic       prio_hit
    );
        pal_addr_t res;
        if (obj_pen && prio_hit && !tile_prio) begin
            res = {1'b1, obj_col};
        end else begin
            res = {1'b0, tile_col};
        end
        return res;
    endfunction

    // objects use four pen bits, tiles only three
    function automatic logic is_opaque(input pal_addr_t a);
        logic opq;
        if (a[PAL_OBJ_BIT]) begin
            opq = |a[3:0];
        end else begin
            opq = |a[2:0];
        end
        return opq;
    endfunction

    // sample all layers at the pixel enable
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lyr0 <= '0;
            lyr1 <= '0;
            lyr2 <= '0;
        end else if (pxl_cen) begin
            // char colour is 6 bits, pad to tile width
            lyr0 <= merge_layer({4'd0, char_pxl[5:0]}, char_pxl[6],
                                obj_pxl[9:0], obj_pen_nz, obj_prio == PRIO_CHAR);
            lyr1 <= merge_layer(scr1_pxl[9:0], scr1_pxl[10],
                                obj_pxl[9:0], obj_pen_nz, obj_prio == PRIO_SCR1);
            lyr2 <= merge_layer(scr2_pxl[9:0], scr2_pxl[10],
                                obj_pxl[9:0], obj_pen_nz, obj_prio == PRIO_SCR2);
        end
    end

    // first opaque layer wins, backdrop is entry 0
    always_comb begin
        if (is_opaque(lyr0)) begin
            pal_addr = lyr0;
        end else if (is_opaque(lyr1)) begin
            pal_addr = lyr1;
        end else if (is_opaque(lyr2)) begin
            pal_addr = lyr2;
        end else begin
            pal_addr = '0;
        end
    end

    // object colour never reaches the palette with pen 0
    obj_pen_a: assert property (@(posedge clk) disable iff (!rst_n)
        pal_addr[PAL_OBJ_BIT] |-> pal_addr[3:0] != 4'd0);

endmodule

/* design/cpu_bus_pkg.sv */
/*
 * CPU bus types for palette access
 * request operation and byte enables
 */
`include "colmix_cfg.svh"

package cpu_bus_pkg;

    // request direction
    typedef enum logic {
        CPU_READ  = 1'b0,
        CPU_WRITE = 1'b1
    } cpu_op_e;

    // one enable per byte lane of the palette word
    typedef logic [`COLMIX_PAL_DW/8-1:0] byte_en_t;

    // byte lane positions inside byte_en_t
    localparam int BE_LO = 0;
    localparam int BE_HI = 1;

endpackage

/* design/video_pkg.sv */
/*
 * video types for the colour mixer
 * layer pixel fields, palette address, palette colour, object priority
 */
`include "colmix_cfg.svh"

package video_pkg;

    // pixel bus widths from the tile and object generators
    localparam int CHAR_PXL_W = 7;
    localparam int SCR_PXL_W  = 11;
    localparam int OBJ_PXL_W  = 12;

    // palette address bit that marks an object colour
    localparam int PAL_OBJ_BIT = 10;

    // bit 10 object, bits 3:0 pen in colour group
    typedef logic [`COLMIX_PAL_AW-1:0] pal_addr_t;

    // low colour bits live in the top of the word
    typedef struct packed {
        logic       b_lo;
        logic       g_lo;
        logic       r_lo;
        logic [3:0] b_hi;
        logic [3:0] g_hi;
        logic [3:0] r_hi;
    } rgb15_t;

    // object priority, which tile layer the object beats
    typedef enum logic [1:0] {
        PRIO_LOW  = 2'd0,
        PRIO_SCR2 = 2'd1,
        PRIO_SCR1 = 2'd2,
        PRIO_CHAR = 2'd3
    } obj_prio_e;

endpackage

/* include/colmix_cfg.svh */
/*
 * colour mixer configuration
 * palette geometry and depth of the colour/blank delay line
 */
`ifndef COLMIX_CFG_SVH
`define COLMIX_CFG_SVH

// palette address width, one 16-bit word per address
`define COLMIX_PAL_AW 11

// palette word width
`define COLMIX_PAL_DW 16

// colour/blank delay in pixel enables, counted from the layer sample
`define COLMIX_BLANK_DLY 3

`endif
